// ==== design/exu_pkg.sv ====
// execute stage package: width and step constants, op enums, issue/result/flag structs
package exu_pkg;

  localparam int XLEN = 64;
  localparam int MULDIV_STEPS = 64;
  localparam int STEP_W = 7;

  typedef enum logic [4:0] {
    OP_ADD     = 5'b00000,
    OP_SLL     = 5'b00001,
    OP_SLT     = 5'b00010,
    OP_COPY    = 5'b00011,
    OP_XOR     = 5'b00100,
    OP_SRL     = 5'b00101,
    OP_OR      = 5'b00110,
    OP_AND     = 5'b00111,
    OP_SUB     = 5'b01000,
    OP_SLTU    = 5'b01010,
    OP_SRA     = 5'b01101,
    OP_REMU    = 5'b11001,
    OP_DIVU    = 5'b11010,
    OP_DIV     = 5'b11011,
    OP_MUL     = 5'b11100,
    OP_REM     = 5'b11101,
    OP_EBREAK  = 5'b11110,
    OP_INVALID = 5'b11111
  } alu_op_e;

  // signedness of blt/bge follows the op (slt or sltu)
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef enum logic [1:0] {
    TRAP_NONE    = 2'b00,
    TRAP_EBREAK  = 2'b01,
    TRAP_INVALID = 2'b10
  } trap_e;

  // source B of the ALU
  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10
  } b_sel_e;

  typedef struct packed {
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rdata;
    logic            alu_a_pc;
    b_sel_e          alu_b_sel;
    alu_op_e         op;
    logic            word_cut;
    branch_e         branch;
    mem_op_e         mem_op;
    logic            mem_to_reg;
  } exu_issue_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] bus_w;
    trap_e           trap;
  } exu_result_t;

  typedef struct packed {
    logic zero;
    logic less;
  } alu_flags_t;

  function automatic logic is_muldiv(alu_op_e op);
    return (op == OP_MUL) || (op == OP_DIV) || (op == OP_DIVU) ||
           (op == OP_REM) || (op == OP_REMU);
  endfunction

endpackage

// ==== design/exu_alu.sv ====
// single-cycle ALU: operand select, word cut, add/sub/compare, logic, shifts, flags
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::exu_issue_t      i_src,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output exu_pkg::alu_flags_t      o_flags
);
  import exu_pkg::*;

  logic [XLEN-1:0] raw_a;
  logic [XLEN-1:0] raw_b;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] b_inv;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] alu_raw;
  logic [5:0]      shamt;
  logic            do_sub;
  logic            cout;
  logic            overflow;
  logic            signed_less;
  logic            unsigned_less;

  always_comb begin
    raw_a = i_src.alu_a_pc ? i_src.pc : i_src.rs1;
    case (i_src.alu_b_sel)
      B_RS2:   raw_b = i_src.rs2;
      B_IMM:   raw_b = i_src.imm;
      default: raw_b = XLEN'(4);
    endcase
  end

  // word ops see 32-bit sources, sra keeps the sign for the shift-in
  always_comb begin
    src_a = raw_a;
    src_b = raw_b;
    if (i_src.word_cut) begin
      if (i_src.op == OP_SRA) begin
        src_a = {{32{raw_a[31]}}, raw_a[31:0]};
      end else begin
        src_a = {32'b0, raw_a[31:0]};
      end
      src_b = {32'b0, raw_b[31:0]};
    end
  end

  // one adder, subtract mode for everything but add
  assign do_sub = (i_src.op != OP_ADD);
  assign b_inv  = do_sub ? ~src_b : src_b;
  assign {cout, sum} = {1'b0, src_a} + {1'b0, b_inv} + {{XLEN{1'b0}}, do_sub};

  assign overflow      = (src_a[XLEN-1] == b_inv[XLEN-1]) && (sum[XLEN-1] != src_a[XLEN-1]);
  assign signed_less   = sum[XLEN-1] ^ overflow;
  // borrow out of a - b
  assign unsigned_less = ~cout;

  assign shamt = i_src.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  always_comb begin
    case (i_src.op)
      OP_COPY:        alu_raw = i_src.imm;
      OP_ADD, OP_SUB: alu_raw = sum;
      OP_SLT:         alu_raw = {{(XLEN-1){1'b0}}, signed_less};
      OP_SLTU:        alu_raw = {{(XLEN-1){1'b0}}, unsigned_less};
      OP_XOR:         alu_raw = src_a ^ src_b;
      OP_AND:         alu_raw = src_a & src_b;
      OP_OR:          alu_raw = src_a | src_b;
      OP_SLL:         alu_raw = src_a << shamt;
      OP_SRL:         alu_raw = src_a >> shamt;
      OP_SRA:         alu_raw = $signed(src_a) >>> shamt;
      default:        alu_raw = '0;
    endcase
  end

  assign o_result = i_src.word_cut ? {{32{alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign o_flags.zero = (sum == '0);
  assign o_flags.less = (i_src.op == OP_SLTU) ? unsigned_less : signed_less;

endmodule

// ==== design/exu_branch.sv ====
// branch unit: taken decision from branch kind and ALU flags, next-pc adder
`timescale 1ns/1ps

module exu_branch (
  input  exu_pkg::exu_issue_t      i_src,
  input  exu_pkg::alu_flags_t      i_flags,
  output logic [exu_pkg::XLEN-1:0] o_next_pc
);
  import exu_pkg::*;

  logic            taken;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offset;

  always_comb begin
    case (i_src.branch)
      BR_JAL,
      BR_JALR: taken = 1'b1;
      BR_BEQ:  taken = i_flags.zero;
      BR_BNE:  taken = ~i_flags.zero;
      BR_BLT:  taken = i_flags.less;
      BR_BGE:  taken = ~i_flags.less;
      default: taken = 1'b0;
    endcase
  end

  // jalr jumps off rs1, everything else off pc
  assign base   = (i_src.branch == BR_JALR) ? i_src.rs1 : i_src.pc;
  assign offset = taken ? i_src.imm : XLEN'(4);

  assign o_next_pc = base + offset;

endmodule

// ==== design/exu_load_ext.sv ====
// load data extension by size and sign, write-back select
`timescale 1ns/1ps

module exu_load_ext (
  input  logic [exu_pkg::XLEN-1:0] i_rdata,
  input  exu_pkg::mem_op_e         i_mem_op,
  input  logic                     i_mem_to_reg,
  input  logic [exu_pkg::XLEN-1:0] i_alu_result,
  output logic [exu_pkg::XLEN-1:0] o_bus_w
);
  import exu_pkg::*;

  logic [XLEN-1:0] load_val;

  always_comb begin
    case (i_mem_op)
      MEM_LB:  load_val = {{56{i_rdata[7]}}, i_rdata[7:0]};
      MEM_LBU: load_val = {56'b0, i_rdata[7:0]};
      MEM_LH:  load_val = {{48{i_rdata[15]}}, i_rdata[15:0]};
      MEM_LHU: load_val = {48'b0, i_rdata[15:0]};
      MEM_LW:  load_val = {{32{i_rdata[31]}}, i_rdata[31:0]};
      MEM_LWU: load_val = {32'b0, i_rdata[31:0]};
      MEM_LD:  load_val = i_rdata;
      default: load_val = '0;
    endcase
  end

  assign o_bus_w = i_mem_to_reg ? load_val : i_alu_result;

endmodule

// ==== design/exu_muldiv.sv ====
// iterative multiply (shift-add) and restoring divide with sign and divide-by-zero fixup
`timescale 1ns/1ps

module exu_muldiv (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_start,
  input  logic                     i_step,
  input  logic                     i_last,
  input  exu_pkg::alu_op_e         i_op,
  input  logic                     i_word_cut,
  input  logic [exu_pkg::XLEN-1:0] i_a,
  input  logic [exu_pkg::XLEN-1:0] i_b,
  output logic [exu_pkg::XLEN-1:0] o_result
);
  import exu_pkg::*;

  logic            is_mul;
  logic            is_rem;
  logic            is_signed;
  logic            neg_a;
  logic            neg_b;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;

  logic            mul_q;
  logic            rem_q;
  logic            word_q;
  logic            neg_quo_q;
  logic            neg_rem_q;
  logic            div_zero_q;
  // acc holds product or partial remainder, mq multiplier or quotient, md multiplicand or divisor
  logic [XLEN-1:0] acc_q;
  logic [XLEN-1:0] mq_q;
  logic [XLEN-1:0] md_q;

  logic [XLEN:0]   rem_sh;
  logic [XLEN:0]   trial;
  logic            fits;
  logic [XLEN-1:0] acc_nxt;
  logic [XLEN-1:0] mq_nxt;
  logic [XLEN-1:0] md_nxt;
  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rmd;
  logic [XLEN-1:0] res;

  assign is_mul    = (i_op == OP_MUL);
  assign is_rem    = (i_op == OP_REM) || (i_op == OP_REMU);
  assign is_signed = (i_op == OP_DIV) || (i_op == OP_REM);

  always_comb begin
    src_a = i_a;
    src_b = i_b;
    if (i_word_cut) begin
      src_a = is_signed ? {{32{i_a[31]}}, i_a[31:0]} : {32'b0, i_a[31:0]};
      src_b = is_signed ? {{32{i_b[31]}}, i_b[31:0]} : {32'b0, i_b[31:0]};
    end
  end

  assign neg_a = is_signed & src_a[XLEN-1];
  assign neg_b = is_signed & src_b[XLEN-1];
  assign mag_a = neg_a ? -src_a : src_a;
  assign mag_b = neg_b ? -src_b : src_b;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mul_q      <= 1'b0;
      rem_q      <= 1'b0;
      word_q     <= 1'b0;
      neg_quo_q  <= 1'b0;
      neg_rem_q  <= 1'b0;
      div_zero_q <= 1'b0;
    end else if (i_start) begin
      mul_q      <= is_mul;
      rem_q      <= is_rem;
      word_q     <= i_word_cut;
      neg_quo_q  <= neg_a ^ neg_b;
      neg_rem_q  <= neg_a;
      div_zero_q <= (src_b == '0);
    end
  end

  // restoring divide step on {acc, top bit of quotient reg}
  assign rem_sh = {acc_q, mq_q[XLEN-1]};
  assign trial  = rem_sh - {1'b0, md_q};
  // no borrow out of the trial subtract
  assign fits   = ~trial[XLEN];

  always_comb begin
    if (mul_q) begin
      acc_nxt = acc_q + (mq_q[0] ? md_q : '0);
      mq_nxt  = mq_q >> 1;
      md_nxt  = md_q << 1;
    end else begin
      acc_nxt = fits ? trial[XLEN-1:0] : rem_sh[XLEN-1:0];
      mq_nxt  = {mq_q[XLEN-2:0], fits};
      md_nxt  = md_q;
    end
  end

  // signed overflow falls out of the magnitudes since |min| / 1 wraps back to min
  assign quo = div_zero_q ? '1 : (neg_quo_q ? -mq_nxt : mq_nxt);
  assign rmd = neg_rem_q ? -acc_nxt : acc_nxt;
  assign res = mul_q ? acc_nxt : (rem_q ? rmd : quo);

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      acc_q <= '0;
      mq_q  <= is_mul ? src_b : mag_a;
      md_q  <= is_mul ? src_a : mag_b;
    end else if (i_step) begin
      acc_q <= acc_nxt;
      mq_q  <= mq_nxt;
      md_q  <= md_nxt;
    end
    if (i_step && i_last) begin
      o_result <= word_q ? {{32{res[31]}}, res[31:0]} : res;
    end
  end

endmodule

// ==== design/exu_step_counter.sv ====
// multiply/divide step counter with step and last-step strobes
`timescale 1ns/1ps

module exu_step_counter (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_step,
  output logic o_last
);
  import exu_pkg::*;

  // steps left, zero when idle
  logic [STEP_W-1:0] cnt_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      cnt_q <= '0;
    end else if (i_start) begin
      cnt_q <= STEP_W'(MULDIV_STEPS);
    end else if (o_step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign o_step = (cnt_q != '0);
  assign o_last = (cnt_q == STEP_W'(1));

endmodule

// ==== design/exu_ctrl.sv ====
// execute sequencing FSM: accept, single-cycle or iterative path, result load, done
`timescale 1ns/1ps

module exu_ctrl (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_issue,
  input  exu_pkg::alu_op_e i_op,
  input  logic             i_last,
  output logic             o_latch,
  output logic             o_md_start,
  output logic             o_res_load,
  output logic             o_done,
  output logic             o_busy
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DECIDE,
    S_RUN,
    S_FINISH
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   md_op;
  logic   done_q;

  // op comes from the operand register, stable for the whole instruction
  assign md_op = is_muldiv(i_op);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (i_issue) state_d = S_DECIDE;
      S_DECIDE: state_d = md_op ? S_RUN : S_IDLE;
      S_RUN:    if (i_last) state_d = S_FINISH;
      default:  state_d = S_IDLE;
    endcase
  end

  assign o_latch    = (state_q == S_IDLE) && i_issue;
  assign o_md_start = (state_q == S_DECIDE) && md_op;
  // single-cycle ops load in decide, iterative ones once the last step is in
  assign o_res_load = ((state_q == S_DECIDE) && !md_op) || (state_q == S_FINISH);
  assign o_busy     = (state_q != S_IDLE);
  assign o_done     = done_q;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state_q <= S_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= o_res_load;
    end
  end

endmodule

// ==== design/exu_top.sv ====
// execute stage top: operand register, ALU, branch, load ext, mul/div, control, result register
`timescale 1ns/1ps

module exu_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_issue,
  input  exu_pkg::exu_issue_t   i_op,
  output logic                  o_done,
  output logic                  o_busy,
  output exu_pkg::exu_result_t  o_result
);
  import exu_pkg::*;

  exu_issue_t      op_q;
  alu_flags_t      flags;
  trap_e           trap;
  logic            latch;
  logic            md_start;
  logic            md_step;
  logic            md_last;
  logic            res_load;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] md_result;
  logic [XLEN-1:0] exe_result;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] bus_w;

  always_ff @(posedge i_clk) begin
    if (latch) begin
      op_q <= i_op;
    end
  end

  exu_ctrl u_ctrl (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_issue    (i_issue),
    .i_op       (op_q.op),
    .i_last     (md_last),
    .o_latch    (latch),
    .o_md_start (md_start),
    .o_res_load (res_load),
    .o_done     (o_done),
    .o_busy     (o_busy)
  );

  exu_alu u_alu (
    .i_src    (op_q),
    .o_result (alu_result),
    .o_flags  (flags)
  );

  exu_branch u_branch (
    .i_src     (op_q),
    .i_flags   (flags),
    .o_next_pc (next_pc)
  );

  exu_step_counter u_step_counter (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_start (md_start),
    .o_step  (md_step),
    .o_last  (md_last)
  );

  exu_muldiv u_muldiv (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_start    (md_start),
    .i_step     (md_step),
    .i_last     (md_last),
    .i_op       (op_q.op),
    .i_word_cut (op_q.word_cut),
    .i_a        (op_q.rs1),
    .i_b        (op_q.rs2),
    .o_result   (md_result)
  );

  // both results arrive already word-cut
  assign exe_result = is_muldiv(op_q.op) ? md_result : alu_result;

  exu_load_ext u_load_ext (
    .i_rdata      (op_q.rdata),
    .i_mem_op     (op_q.mem_op),
    .i_mem_to_reg (op_q.mem_to_reg),
    .i_alu_result (exe_result),
    .o_bus_w      (bus_w)
  );

  always_comb begin
    case (op_q.op)
      OP_EBREAK:  trap = TRAP_EBREAK;
      OP_INVALID: trap = TRAP_INVALID;
      default:    trap = TRAP_NONE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_result <= '0;
    end else if (res_load) begin
      o_result.alu_result <= exe_result;
      o_result.next_pc    <= next_pc;
      o_result.bus_w      <= bus_w;
      o_result.trap       <= trap;
    end
  end

endmodule

// ==== dv/tb_clock.sv ====
// testbench clock generator, free running from time zero
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_NS = 2
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #(HALF_NS) o_clk = ~o_clk;
    end
  end

endmodule

// ==== dv/exu_model.svh ====
// reference model: operand select, ALU, mul/div, branch target, load extension, full result
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

function automatic logic [63:0] sext32(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic logic [63:0] operand_a(input exu_issue_t t);
  return t.alu_a_pc ? t.pc : t.rs1;
endfunction

function automatic logic [63:0] operand_b(input exu_issue_t t);
  logic [63:0] b;
  case (t.alu_b_sel)
    B_RS2:   b = t.rs2;
    B_IMM:   b = t.imm;
    default: b = 64'd4;
  endcase
  return b;
endfunction

function automatic logic [63:0] alu_expect(input exu_issue_t t);
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] r;
  logic [5:0]  sh;
  a = operand_a(t);
  b = operand_b(t);
  // word ops: 32-bit sources, only sra keeps the sign
  if (t.word_cut) begin
    a = (t.op == OP_SRA) ? sext32(a[31:0]) : {32'b0, a[31:0]};
    b = {32'b0, b[31:0]};
  end
  sh = t.word_cut ? {1'b0, b[4:0]} : b[5:0];
  case (t.op)
    OP_COPY: r = t.imm;
    OP_ADD:  r = a + b;
    OP_SUB:  r = a - b;
    OP_SLT:  r = {63'b0, $signed(a) < $signed(b)};
    OP_SLTU: r = {63'b0, a < b};
    OP_XOR:  r = a ^ b;
    OP_AND:  r = a & b;
    OP_OR:   r = a | b;
    OP_SLL:  r = a << sh;
    OP_SRL:  r = a >> sh;
    OP_SRA:  r = $signed(a) >>> sh;
    default: r = '0;
  endcase
  return t.word_cut ? sext32(r[31:0]) : r;
endfunction

function automatic logic [63:0] muldiv_expect(input exu_issue_t t);
  logic               signed_op;
  logic [63:0]        a;
  logic [63:0]        b;
  logic signed [63:0] q;
  logic signed [63:0] rm;
  logic [63:0]        r;
  signed_op = (t.op == OP_DIV) || (t.op == OP_REM);
  a = t.rs1;
  b = t.rs2;
  if (t.word_cut) begin
    a = signed_op ? sext32(t.rs1[31:0]) : {32'b0, t.rs1[31:0]};
    b = signed_op ? sext32(t.rs2[31:0]) : {32'b0, t.rs2[31:0]};
  end
  // x/0 is all ones, x%0 is x, min/-1 is min, min%-1 is 0
  if (b == '0) begin
    q = -1;
    rm = a;
  end else if (signed_op && (a == 64'h8000_0000_0000_0000) && (b == '1)) begin
    q = a;
    rm = '0;
  end else if (signed_op) begin
    q = $signed(a) / $signed(b);
    rm = $signed(a) % $signed(b);
  end else begin
    q = a / b;
    rm = a % b;
  end
  case (t.op)
    OP_MUL:          r = a * b;
    OP_DIV, OP_DIVU: r = q;
    default:         r = rm;
  endcase
  return t.word_cut ? sext32(r[31:0]) : r;
endfunction

// full-width compare, branch bundles carry no word cut
function automatic logic [63:0] branch_target(input exu_issue_t t);
  logic [63:0] a;
  logic [63:0] b;
  logic        lt;
  logic        taken;
  a = operand_a(t);
  b = operand_b(t);
  lt = (t.op == OP_SLTU) ? (a < b) : ($signed(a) < $signed(b));
  case (t.branch)
    BR_JAL, BR_JALR: taken = 1'b1;
    BR_BEQ:          taken = (a == b);
    BR_BNE:          taken = (a != b);
    BR_BLT:          taken = lt;
    BR_BGE:          taken = !lt;
    default:         taken = 1'b0;
  endcase
  return ((t.branch == BR_JALR) ? t.rs1 : t.pc) + (taken ? t.imm : 64'd4);
endfunction

function automatic logic [63:0] load_writeback(input exu_issue_t t, input logic [63:0] res);
  logic [63:0] v;
  case (t.mem_op)
    MEM_LB:  v = {{56{t.rdata[7]}}, t.rdata[7:0]};
    MEM_LBU: v = {56'b0, t.rdata[7:0]};
    MEM_LH:  v = {{48{t.rdata[15]}}, t.rdata[15:0]};
    MEM_LHU: v = {48'b0, t.rdata[15:0]};
    MEM_LW:  v = sext32(t.rdata[31:0]);
    MEM_LWU: v = {32'b0, t.rdata[31:0]};
    default: v = t.rdata;
  endcase
  return t.mem_to_reg ? v : res;
endfunction

function automatic exu_result_t expected_result(input exu_issue_t t);
  exu_result_t r;
  logic        md;
  md = t.op inside {OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  r.alu_result = md ? muldiv_expect(t) : alu_expect(t);
  r.next_pc = branch_target(t);
  r.bus_w = load_writeback(t, r.alu_result);
  case (t.op)
    OP_EBREAK:  r.trap = TRAP_EBREAK;
    OP_INVALID: r.trap = TRAP_INVALID;
    default:    r.trap = TRAP_NONE;
  endcase
  return r;
endfunction

`endif

// ==== dv/exu_tb.sv ====
// testbench top with reset, LCG stimulus, model checks, issue timing, busy drop, timeout, report
`timescale 1ns/1ps

module exu_tb;
  import exu_pkg::*;

  `include "exu_model.svh"

  localparam logic [63:0] SEED = 64'd85466;
  localparam int SHORT_LAT = 2;
  localparam int LONG_LAT = MULDIV_STEPS + 3;
  localparam int DONE_WAIT = 2 * LONG_LAT;
  // the busy window counts as two issues
  localparam int NUM_ISSUES = 300 + 200 + 100 + 150 + 2;
  localparam int TIMEOUT_CYCLES = NUM_ISSUES * LONG_LAT + 200;

  localparam alu_op_e SINGLE_OPS [13] = '{OP_COPY, OP_ADD, OP_SLT, OP_SLTU, OP_SUB, OP_XOR,
    OP_AND, OP_OR, OP_SLL, OP_SRL, OP_SRA, OP_EBREAK, OP_INVALID};
  localparam alu_op_e MD_OPS [5] = '{OP_MUL, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  localparam alu_op_e CMP_OPS [3] = '{OP_SLT, OP_SLTU, OP_SUB};
  localparam branch_e BRANCHES [6] = '{BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE};

  logic        clk;
  logic        rst_n;
  logic        issue;
  exu_issue_t  op_in;
  logic        done;
  logic        busy;
  exu_result_t result;

  logic [63:0] rng_state;
  int          cycle_count;
  int          errors;
  int          tests_run;
  int          tests_failed;

  tb_clock #(.HALF_NS(2)) u_clk (.o_clk(clk));

  exu_top i_exu_top (
    .i_clk    (clk),
    .i_rst_n  (rst_n),
    .i_issue  (issue),
    .i_op     (op_in),
    .o_done   (done),
    .o_busy   (busy),
    .o_result (result)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return rng_state[63:32];
  endfunction

  function automatic int pick(input int n);
    return int'(next_rand() % n);
  endfunction

  function automatic logic coin();
    logic [31:0] r;
    r = next_rand();
    return r[31];
  endfunction

  // mix of small, small negative, 32-bit signed and full random values
  function automatic logic [63:0] rand_operand();
    logic [31:0] hi;
    logic [31:0] lo;
    logic [63:0] v;
    hi = next_rand();
    lo = next_rand();
    case (pick(4))
      0:       v = {56'b0, lo[7:0]};
      1:       v = ~{56'b0, lo[7:0]};
      2:       v = sext32(lo);
      default: v = {hi, lo};
    endcase
    return v;
  endfunction

  function automatic exu_issue_t random_bundle();
    exu_issue_t t;
    t.rs1 = rand_operand();
    t.rs2 = rand_operand();
    t.imm = rand_operand();
    t.pc = rand_operand() & ~64'h3;
    t.rdata = rand_operand();
    t.alu_a_pc = coin();
    t.alu_b_sel = b_sel_e'(pick(3));
    t.op = OP_ADD;
    t.word_cut = coin();
    t.branch = BR_NONE;
    t.mem_op = mem_op_e'(pick(7));
    t.mem_to_reg = 1'b0;
    return t;
  endfunction

  task automatic compare_result(input string what, input exu_result_t got,
                                input exu_result_t exp);
    if (got.alu_result !== exp.alu_result) begin
      $display("** Error @%0t: %s alu_result %h, expected %h", $time, what,
               got.alu_result, exp.alu_result);
      errors++;
    end
    if (got.next_pc !== exp.next_pc) begin
      $display("** Error @%0t: %s next_pc %h, expected %h", $time, what,
               got.next_pc, exp.next_pc);
      errors++;
    end
    if (got.bus_w !== exp.bus_w) begin
      $display("** Error @%0t: %s bus_w %h, expected %h", $time, what, got.bus_w, exp.bus_w);
      errors++;
    end
    if (got.trap !== exp.trap) begin
      $display("** Error @%0t: %s trap %b, expected %b", $time, what, got.trap, exp.trap);
      errors++;
    end
  endtask

  // starts on a falling edge and returns on the one where o_done is seen
  task automatic run_op(input exu_issue_t t, input int exp_lat, input string what);
    exu_result_t exp;
    int          lat;
    exp = expected_result(t);
    issue = 1'b1;
    op_in = t;
    lat = 0;
    do begin
      @(negedge clk);
      issue = 1'b0;
      lat++;
    end while (!done && lat < DONE_WAIT);
    if (!done) begin
      $display("%s: o_done did not come within %0d cycles", what, DONE_WAIT);
      errors++;
    end else begin
      if (lat != exp_lat) begin
        $display("** Error @%0t: %s o_done after %0d cycles, expected %0d", $time, what,
                 lat, exp_lat);
        errors++;
      end
      compare_result(what, result, exp);
    end
  endtask

  task automatic finish_test(input string name, input int issues, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
    end
    $display("test %s: %0d issues, %0d errors", name, issues, errors - err_before);
  endtask

  task automatic check_reset_state();
    int err_before;
    err_before = errors;
    if (done !== 1'b0 || busy !== 1'b0) begin
      $display("** Error @%0t: after reset o_done %b o_busy %b, expected 0", $time, done, busy);
      errors++;
    end
    if (result !== '0) begin
      $display("** Error @%0t: after reset o_result %h, expected 0", $time, result);
      errors++;
    end
    finish_test("reset state", 0, err_before);
  endtask

  task automatic single_op_sweep();
    exu_issue_t t;
    int         i;
    int         err_before;
    err_before = errors;
    for (i = 0; i < 300; i++) begin
      t = random_bundle();
      t.op = SINGLE_OPS[pick(13)];
      run_op(t, SHORT_LAT, $sformatf("single op %0d (op %b)", i, t.op));
    end
    finish_test("single-cycle ops", 300, err_before);
  endtask

  task automatic branch_sweep();
    exu_issue_t t;
    int         i;
    int         err_before;
    err_before = errors;
    for (i = 0; i < 200; i++) begin
      t = random_bundle();
      t.word_cut = 1'b0;
      t.alu_a_pc = 1'b0;
      t.alu_b_sel = B_RS2;
      t.op = CMP_OPS[pick(3)];
      t.branch = BRANCHES[pick(6)];
      if (pick(4) == 0) begin
        t.rs2 = t.rs1;
      end
      run_op(t, SHORT_LAT, $sformatf("branch %0d (kind %b)", i, t.branch));
    end
    finish_test("branches and jumps", 200, err_before);
  endtask

  task automatic load_sweep();
    exu_issue_t t;
    int         i;
    int         err_before;
    err_before = errors;
    for (i = 0; i < 100; i++) begin
      t = random_bundle();
      t.op = SINGLE_OPS[pick(13)];
      t.mem_op = mem_op_e'(i % 7);
      t.mem_to_reg = coin();
      run_op(t, SHORT_LAT, $sformatf("load %0d (mem_op %b)", i, t.mem_op));
    end
    finish_test("load extension", 100, err_before);
  endtask

  task automatic muldiv_sweep();
    exu_issue_t t;
    int         i;
    int         err_before;
    err_before = errors;
    for (i = 0; i < 150; i++) begin
      t = random_bundle();
      t.op = MD_OPS[pick(5)];
      if (i % 10 == 0) begin
        t.rs2 = t.word_cut ? {t.rs2[63:32], 32'b0} : '0;
      end else if (i % 10 == 1) begin
        // most negative over minus one
        t.op = (i % 20 == 1) ? OP_DIV : OP_REM;
        t.rs1 = t.word_cut ? {t.rs1[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
        t.rs2 = t.word_cut ? {t.rs2[63:32], 32'hffff_ffff} : '1;
      end
      run_op(t, LONG_LAT, $sformatf("muldiv %0d (op %b, word %b)", i, t.op, t.word_cut));
    end
    finish_test("multiply and divide", 150, err_before);
  endtask

  task automatic busy_drop_check();
    exu_issue_t  first;
    exu_issue_t  second;
    exu_result_t exp;
    exu_result_t got;
    int          c;
    int          done_seen;
    int          done_at;
    int          err_before;
    err_before = errors;
    first = random_bundle();
    first.op = OP_DIVU;
    second = random_bundle();
    second.op = OP_XOR;
    exp = expected_result(first);
    got = '0;
    done_seen = 0;
    done_at = 0;
    issue = 1'b1;
    op_in = first;
    for (c = 1; c <= DONE_WAIT; c++) begin
      @(negedge clk);
      issue = 1'b0;
      if (c == 1 || c == 10) begin
        if (!busy) begin
          $display("o_busy is low at cycle %0d of a running divide", c);
          errors++;
        end
        issue = 1'b1;
        op_in = second;
      end
      if (done) begin
        done_seen++;
        if (done_seen == 1) begin
          done_at = c;
          got = result;
        end
      end
    end
    if (done_seen != 1 || done_at != LONG_LAT) begin
      $display("** Error @%0t: busy issue gave %0d o_done pulses, first at cycle %0d", $time,
               done_seen, done_at);
      errors++;
    end
    if (done_seen > 0) begin
      compare_result("busy drop", got, exp);
    end
    finish_test("issue while busy", 2, err_before);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles", cycle_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    issue = 1'b0;
    op_in = '0;
    rng_state = SEED;
    cycle_count = 0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    single_op_sweep();
    branch_sweep();
    load_sweep();
    muldiv_sweep();
    busy_drop_check();
    $display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+dv
design/exu_pkg.sv
design/exu_alu.sv
design/exu_branch.sv
design/exu_load_ext.sv
design/exu_muldiv.sv
design/exu_step_counter.sv
design/exu_ctrl.sv
design/exu_top.sv
dv/tb_clock.sv
dv/exu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILE_LIST  ?= all.f
TB_TOP     ?= exu_tb
RTL_TOP    ?= exu_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
VFLAGS     ?= --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
	  -Mdir $(OBJ_DIR) -o $(TB_TOP)

sim: build
	-./$(OBJ_DIR)/$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
	  echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
